// ==== hdl/opl3_mix_defs.svh ====
/*
 * Widths and counts for the OPL3 channel mixer.
 * Operator samples and outputs are signed two's complement.
 * The accumulator width covers 18 slots of three-operator sums.
 */
`ifndef OPL3_MIX_DEFS_SVH
`define OPL3_MIX_DEFS_SVH

`define OPL3_OP_OUT_WIDTH 13 // signed operator sample
`define OPL3_SAMPLE_WIDTH 16 // signed clamped output
`define OPL3_ACC_WIDTH    19 // pre-clamp accumulator
`define OPL3_NUM_CHANNELS 9  // channels per bank
`define OPL3_NUM_SLOTS    18 // operator slots per bank
`define OPL3_NUM_OUTPUTS  4  // channel a to d

`endif

// ==== hdl/opl3_mix_pkg.sv ====
/*
 * Shared types for the mixer. Register bytes follow the OPL3 layout.
 * The fb field is decoded but never stored.
 */
`default_nettype none

package opl3_mix_pkg;

    typedef struct packed {
        logic       chd;
        logic       chc;
        logic       chb;
        logic       cha;
        logic [2:0] fb;  // feedback, ignored here
        logic       cnt;
    } chan_ctrl_t;       // 0xC0-0xC8

    typedef struct packed {
        logic [1:0] unused;
        logic [5:0] conn_sel; // bits 0-2 bank 0, bits 3-5 bank 1
    } four_op_t;              // 0x104

    // one write byte, read per address
    typedef union packed {
        chan_ctrl_t ctrl;
        four_op_t   four_op;
        logic [7:0] raw;
    } reg_byte_u;

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        LOAD
    } mix_state_t;

    typedef struct packed {
        logic       bank;
        logic [3:0] channel;
    } slot_pos_t;

endpackage

`default_nettype wire

// ==== hdl/slot_if.sv ====
/*
 * Slot position and pass step strobes shared by the sequencer,
 * the counter and the accumulators.
 */
`timescale 1ns/1ps
`default_nettype none

interface slot_if;
    logic                    calc;  // current slot valid
    logic                    clear; // zero accumulators
    logic                    load;  // clamp and present
    opl3_mix_pkg::slot_pos_t pos;
    logic                    last;  // bank 1 channel 8

    modport seq_mp (output calc, clear, load, input pos, last);
    modport cnt_mp (input calc, output pos, last);
    modport data_mp (input calc, clear, load, pos);
endinterface

`default_nettype wire

// ==== hdl/mix_sequencer.sv ====
/*
 * Pass control. sample_clk_en starts a pass only from IDLE.
 * Clear coincides with the first slot, load follows the last one.
 */
`timescale 1ns/1ps
`default_nettype none

module mix_sequencer (
    input wire    clk,
    input wire    reset,
    input wire    sample_clk_en,
    slot_if.seq_mp slot
);
    opl3_mix_pkg::mix_state_t state;
    opl3_mix_pkg::mix_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset)
            state <= opl3_mix_pkg::IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        unique case (state)
            opl3_mix_pkg::IDLE:
                next_state = sample_clk_en ? opl3_mix_pkg::CALC : opl3_mix_pkg::IDLE;
            opl3_mix_pkg::CALC:
                next_state = slot.last ? opl3_mix_pkg::LOAD : opl3_mix_pkg::CALC;
            default:
                next_state = opl3_mix_pkg::IDLE;
        endcase
    end

    assign slot.calc  = (state == opl3_mix_pkg::CALC);
    assign slot.clear = slot.calc && (slot.pos == '0); // first slot of the pass
    assign slot.load  = (state == opl3_mix_pkg::LOAD);

    // counter parked at the first slot between passes
    a_idle_at_start: assert property (@(posedge clk) disable iff (reset)
        state == opl3_mix_pkg::IDLE |-> slot.pos == '0);
    a_load_after_last: assert property (@(posedge clk) disable iff (reset)
        slot.calc && slot.last |=> slot.load ##1 !slot.load);
endmodule

`default_nettype wire

// ==== hdl/slot_counter.sv ====
/*
 * Walks bank 0 channels 0-8, then bank 1 channels 0-8, one step
 * per calc cycle. Wraps to the start after the last slot.
 */
`timescale 1ns/1ps
`default_nettype none
`include "opl3_mix_defs.svh"

module slot_counter (
    input wire     clk,
    input wire     reset,
    slot_if.cnt_mp slot
);
    localparam int LAST_CH = `OPL3_NUM_CHANNELS - 1;

    always_ff @(posedge clk) begin
        if (reset) begin
            slot.pos <= '0;
        end else if (slot.calc) begin
            if (slot.last) begin
                slot.pos <= '0; // ready for next pass
            end else if (slot.pos.channel == 4'(LAST_CH)) begin
                slot.pos.bank    <= 1'b1;
                slot.pos.channel <= '0;
            end else begin
                slot.pos.channel <= slot.pos.channel + 4'd1;
            end
        end
    end

    assign slot.last = slot.pos.bank && (slot.pos.channel == 4'(LAST_CH));

    a_channel_range: assert property (@(posedge clk) disable iff (reset)
        slot.pos.channel <= 4'(LAST_CH));
endmodule

`default_nettype wire

// ==== hdl/operator_sample_ram.sv ====
/*
 * 36 operator samples, index = bank*18 + slot. Addresses 36-63 are
 * dropped. Reads return operators ch, ch+3, ch+6, ch+9 of the bank.
 */
`timescale 1ns/1ps
`default_nettype none
`include "opl3_mix_defs.svh"

module operator_sample_ram (
    input wire                                 clk,
    input wire                                 reset,
    input wire                                 op_we,
    input wire [5:0]                           op_addr,
    input wire signed [`OPL3_OP_OUT_WIDTH-1:0] op_data,
    input wire opl3_mix_pkg::slot_pos_t        pos,
    output logic signed [`OPL3_OP_OUT_WIDTH-1:0] op_rd [4]
);
    localparam int DEPTH = 2 * `OPL3_NUM_SLOTS;

    logic signed [`OPL3_OP_OUT_WIDTH-1:0] mem [DEPTH];
    logic [5:0] base;

    always_ff @(posedge clk) begin
        if (op_we && op_addr < 6'(DEPTH))
            mem[op_addr] <= op_data;
    end

    assign base = (pos.bank ? 6'(`OPL3_NUM_SLOTS) : 6'd0) + 6'(pos.channel);

    always_comb begin
        for (int i = 0; i < 4; i++)
            op_rd[i] = mem[base + 6'(3 * i)]; // max index bank*18 + 17
    end

    a_addr_range: assert property (@(posedge clk) disable iff (reset)
        op_we |-> op_addr < 6'(DEPTH));
endmodule

`default_nettype wire

// ==== hdl/channel_config_regs.sv ====
/*
 * OPL3 register decode: 0xC0-0xC8 per bank, 0x104 four-op pairing,
 * 0x105 bit 0 new mode. Other addresses are ignored. The four-op role
 * flags are already qualified by new mode.
 */
`timescale 1ns/1ps
`default_nettype none
`include "opl3_mix_defs.svh"

module channel_config_regs (
    input wire                          clk,
    input wire                          reset,
    input wire                          reg_we,
    input wire [8:0]                    reg_addr,
    input wire [7:0]                    reg_data,
    input wire opl3_mix_pkg::slot_pos_t pos,
    output opl3_mix_pkg::chan_ctrl_t    ctrl,
    output opl3_mix_pkg::chan_ctrl_t    pair_ctrl,
    output logic                        four_op_primary,
    output logic                        four_op_secondary,
    output logic                        is_new
);
    opl3_mix_pkg::chan_ctrl_t ctrl_q [2][`OPL3_NUM_CHANNELS];
    opl3_mix_pkg::reg_byte_u  wr_byte;
    opl3_mix_pkg::chan_ctrl_t wr_ctrl;
    logic [5:0] conn_sel;
    logic [2:0] bank_sel;
    logic [3:0] pair_ch;
    logic       ctrl_hit;

    assign wr_byte.raw = reg_data;
    assign ctrl_hit = reg_addr[7:4] == 4'hC && reg_addr[3:0] < 4'(`OPL3_NUM_CHANNELS);

    always_comb begin
        wr_ctrl    = wr_byte.ctrl;
        wr_ctrl.fb = '0; // feedback not kept
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < 2; b++)
                for (int c = 0; c < `OPL3_NUM_CHANNELS; c++)
                    ctrl_q[b][c] <= '0;
            conn_sel <= '0;
            is_new   <= 1'b0;
        end else if (reg_we) begin
            if (ctrl_hit)
                ctrl_q[reg_addr[8]][reg_addr[3:0]] <= wr_ctrl;
            if (reg_addr == 9'h104)
                conn_sel <= wr_byte.four_op.conn_sel;
            if (reg_addr == 9'h105)
                is_new <= wr_byte.raw[0];
        end
    end

    assign pair_ch   = (pos.channel < 4'd6) ? pos.channel + 4'd3 : pos.channel;
    assign ctrl      = ctrl_q[pos.bank][pos.channel];
    assign pair_ctrl = ctrl_q[pos.bank][pair_ch];
    assign bank_sel  = pos.bank ? conn_sel[5:3] : conn_sel[2:0];

    always_comb begin
        four_op_primary   = 1'b0;
        four_op_secondary = 1'b0;
        if (pos.channel < 4'd3)
            four_op_primary = is_new && bank_sel[pos.channel[1:0]];
        else if (pos.channel < 4'd6)
            four_op_secondary = is_new && bank_sel[2'(pos.channel - 4'd3)];
    end
endmodule

`default_nettype wire

// ==== hdl/channel_combiner.sv ====
/*
 * Per-slot operator sum. op_rd holds operators ch, ch+3, ch+6, ch+9.
 * A four-op secondary channel adds nothing. Bank 0 reaches every
 * output while new mode is off.
 */
`timescale 1ns/1ps
`default_nettype none
`include "opl3_mix_defs.svh"

module channel_combiner (
    input wire signed [`OPL3_OP_OUT_WIDTH-1:0] op_rd [4],
    input wire opl3_mix_pkg::chan_ctrl_t       ctrl,
    input wire opl3_mix_pkg::chan_ctrl_t       pair_ctrl,
    input wire                                 four_op_primary,
    input wire                                 four_op_secondary,
    input wire                                 is_new,
    input wire opl3_mix_pkg::slot_pos_t        pos,
    output logic signed [`OPL3_ACC_WIDTH-1:0]  slot_sum,
    output logic [`OPL3_NUM_OUTPUTS-1:0]       out_en
);
    logic signed [`OPL3_ACC_WIDTH-1:0] op [4];
    logic signed [`OPL3_ACC_WIDTH-1:0] sum_2op;
    logic signed [`OPL3_ACC_WIDTH-1:0] sum_4op;

    always_comb begin
        for (int i = 0; i < 4; i++)
            op[i] = op_rd[i]; // sign extend
    end

    always_comb begin
        if (pos.channel < 4'd3)
            sum_2op = ctrl.cnt ? op[0] + op[1] : op[1];
        else if (pos.channel < 4'd6)
            sum_2op = ctrl.cnt ? op[1] + op[2] : op[2];
        else
            sum_2op = ctrl.cnt ? op[2] + op[3] : op[3];
    end

    always_comb begin
        unique case ({ctrl.cnt, pair_ctrl.cnt})
            2'b00:   sum_4op = op[3];
            2'b01:   sum_4op = op[1] + op[3];
            2'b10:   sum_4op = op[0] + op[3];
            default: sum_4op = op[0] + op[2] + op[3];
        endcase
    end

    assign slot_sum = four_op_primary ? sum_4op :
                      four_op_secondary ? '0 : sum_2op;
    assign out_en = (!is_new && !pos.bank) ? '1 : {ctrl.chd, ctrl.chc, ctrl.chb, ctrl.cha};
endmodule

`default_nettype wire

// ==== hdl/output_accumulator.sv ====
/*
 * Four output accumulators. The first slot of a pass overwrites
 * instead of adding. On load each sum is clamped to 16 bits and held
 * until the next load; sample_valid pulses for one cycle.
 */
`timescale 1ns/1ps
`default_nettype none
`include "opl3_mix_defs.svh"

module output_accumulator (
    input wire                                 clk,
    input wire                                 reset,
    slot_if.data_mp                            slot,
    input wire signed [`OPL3_ACC_WIDTH-1:0]    slot_sum,
    input wire [`OPL3_NUM_OUTPUTS-1:0]         out_en,
    output logic signed [`OPL3_SAMPLE_WIDTH-1:0] channel_a,
    output logic signed [`OPL3_SAMPLE_WIDTH-1:0] channel_b,
    output logic signed [`OPL3_SAMPLE_WIDTH-1:0] channel_c,
    output logic signed [`OPL3_SAMPLE_WIDTH-1:0] channel_d,
    output logic                               sample_valid
);
    localparam logic signed [`OPL3_ACC_WIDTH-1:0] MAX_S = 2 ** (`OPL3_SAMPLE_WIDTH - 1) - 1;
    localparam logic signed [`OPL3_ACC_WIDTH-1:0] MIN_S = -(2 ** (`OPL3_SAMPLE_WIDTH - 1));

    logic signed [`OPL3_ACC_WIDTH-1:0]    acc [`OPL3_NUM_OUTPUTS];
    logic signed [`OPL3_SAMPLE_WIDTH-1:0] out_q [`OPL3_NUM_OUTPUTS];

    function automatic logic signed [`OPL3_SAMPLE_WIDTH-1:0] clamp(
        input logic signed [`OPL3_ACC_WIDTH-1:0] v
    );
        if (v > MAX_S)
            return MAX_S[`OPL3_SAMPLE_WIDTH-1:0];
        else if (v < MIN_S)
            return MIN_S[`OPL3_SAMPLE_WIDTH-1:0];
        else
            return v[`OPL3_SAMPLE_WIDTH-1:0];
    endfunction

    always_ff @(posedge clk) begin
        for (int i = 0; i < `OPL3_NUM_OUTPUTS; i++) begin
            if (slot.calc && out_en[i])
                acc[i] <= (slot.clear ? '0 : acc[i]) + slot_sum;
            else if (slot.clear)
                acc[i] <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `OPL3_NUM_OUTPUTS; i++)
                out_q[i] <= '0;
            sample_valid <= 1'b0;
        end else begin
            if (slot.load) begin
                for (int i = 0; i < `OPL3_NUM_OUTPUTS; i++)
                    out_q[i] <= clamp(acc[i]);
            end
            sample_valid <= slot.load; // one cycle after load
        end
    end

    assign channel_a = out_q[0];
    assign channel_b = out_q[1];
    assign channel_c = out_q[2];
    assign channel_d = out_q[3];
endmodule

`default_nettype wire

// ==== hdl/opl3_channel_mixer.sv ====
/*
 * OPL3 channel mixing stage. Register and operator writes must not
 * happen during a pass. A pass takes 19 cycles from sample_clk_en to
 * sample_valid. Rhythm mode is not supported.
 */
`timescale 1ns/1ps
`default_nettype none
`include "opl3_mix_defs.svh"

module opl3_channel_mixer (
    input wire                                   clk,
    input wire                                   reset,
    input wire                                   sample_clk_en,
    input wire                                   reg_we,
    input wire [8:0]                             reg_addr,
    input wire [7:0]                             reg_data,
    input wire                                   op_we,
    input wire [5:0]                             op_addr,
    input wire signed [`OPL3_OP_OUT_WIDTH-1:0]   op_data,
    output logic signed [`OPL3_SAMPLE_WIDTH-1:0] channel_a,
    output logic signed [`OPL3_SAMPLE_WIDTH-1:0] channel_b,
    output logic signed [`OPL3_SAMPLE_WIDTH-1:0] channel_c,
    output logic signed [`OPL3_SAMPLE_WIDTH-1:0] channel_d,
    output logic                                 sample_valid
);
    slot_if slot ();

    logic signed [`OPL3_OP_OUT_WIDTH-1:0] op_rd [4];
    opl3_mix_pkg::chan_ctrl_t ctrl;
    opl3_mix_pkg::chan_ctrl_t pair_ctrl;
    logic four_op_primary;
    logic four_op_secondary;
    logic is_new;
    logic signed [`OPL3_ACC_WIDTH-1:0] slot_sum;
    logic [`OPL3_NUM_OUTPUTS-1:0] out_en;

    mix_sequencer u_seq (.clk, .reset, .sample_clk_en, .slot(slot.seq_mp));

    slot_counter u_cnt (.clk, .reset, .slot(slot.cnt_mp));

    operator_sample_ram u_ram (
        .clk, .reset, .op_we, .op_addr, .op_data, .pos(slot.pos), .op_rd
    );

    channel_config_regs u_cfg (
        .clk, .reset, .reg_we, .reg_addr, .reg_data, .pos(slot.pos),
        .ctrl, .pair_ctrl, .four_op_primary, .four_op_secondary, .is_new
    );

    channel_combiner u_comb (
        .op_rd, .ctrl, .pair_ctrl, .four_op_primary, .four_op_secondary,
        .is_new, .pos(slot.pos), .slot_sum, .out_en
    );

    output_accumulator u_acc (
        .clk, .reset, .slot(slot.data_mp), .slot_sum, .out_en,
        .channel_a, .channel_b, .channel_c, .channel_d, .sample_valid
    );
endmodule

`default_nettype wire

// ==== sim/tb_opl3_channel_mixer.sv ====
/*
 * Random testbench for the OPL3 channel mixer, with a reference model
 * of registers and operator samples. Writes happen only between passes.
 * A global cycle limit ends a hung run.
 */
`timescale 1ns/1ps
`default_nettype none
`include "opl3_mix_defs.svh"

module tb_opl3_channel_mixer;
    localparam int CYCLE_LIMIT = 40 * 60; // passes times cycles per pass

    logic clk;
    logic reset;
    logic sample_clk_en;
    logic reg_we;
    logic [8:0] reg_addr;
    logic [7:0] reg_data;
    logic op_we;
    logic [5:0] op_addr;
    logic signed [`OPL3_OP_OUT_WIDTH-1:0] op_data;
    logic signed [`OPL3_SAMPLE_WIDTH-1:0] channel_a;
    logic signed [`OPL3_SAMPLE_WIDTH-1:0] channel_b;
    logic signed [`OPL3_SAMPLE_WIDTH-1:0] channel_c;
    logic signed [`OPL3_SAMPLE_WIDTH-1:0] channel_d;
    logic sample_valid;

    logic [7:0] ctrl_m [2][9]; // model of 0xC0-0xC8 per bank
    logic [5:0] conn_m;
    logic       new_m;
    int         op_m [36];
    int errors = 0;
    int tests_run = 0;
    int tests_passed = 0;
    int cycle_count = 0;

    opl3_channel_mixer u_dut (
        .clk, .reset, .sample_clk_en, .reg_we, .reg_addr, .reg_data,
        .op_we, .op_addr, .op_data, .channel_a, .channel_b, .channel_c,
        .channel_d, .sample_valid
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: no finish after %0d cycles, a pass never ended", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic int op_val(input int b, input int n);
        return op_m[b * 18 + n];
    endfunction

    function automatic int channel_value(input int b, input int c);
        int first;
        if (new_m && c < 3 && conn_m[b * 3 + c]) begin
            case ({ctrl_m[b][c][0], ctrl_m[b][c + 3][0]}) // cnt of c, cnt of c+3
                2'b00: return op_val(b, c + 9);
                2'b01: return op_val(b, c + 3) + op_val(b, c + 9);
                2'b10: return op_val(b, c) + op_val(b, c + 9);
                default: return op_val(b, c) + op_val(b, c + 6) + op_val(b, c + 9);
            endcase
        end
        if (new_m && c >= 3 && c < 6 && conn_m[b * 3 + c - 3])
            return 0; // paired half of a four-op channel
        first = (c < 3) ? c : (c < 6) ? c + 3 : c + 6;
        if (ctrl_m[b][c][0])
            return op_val(b, first) + op_val(b, first + 3);
        return op_val(b, first + 3);
    endfunction

    function automatic int expected_out(input int k);
        int sum;
        logic [3:0] en;
        sum = 0;
        for (int b = 0; b < 2; b++) begin
            for (int c = 0; c < 9; c++) begin
                en = ctrl_m[b][c][7:4]; // chd chc chb cha
                if (!new_m && b == 0)
                    en = 4'hF;
                if (en[k])
                    sum += channel_value(b, c);
            end
        end
        if (sum > 32767)
            return 32767;
        if (sum < -32768)
            return -32768;
        return sum;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            errors++;
            $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic compare_outputs();
        check_value("channel_a", expected_out(0), channel_a);
        check_value("channel_b", expected_out(1), channel_b);
        check_value("channel_c", expected_out(2), channel_c);
        check_value("channel_d", expected_out(3), channel_d);
    endtask

    task automatic write_reg(input logic [8:0] addr, input logic [7:0] data);
        reg_we = 1'b1;
        reg_addr = addr;
        reg_data = data;
        @(negedge clk);
        reg_we = 1'b0;
    endtask

    task automatic write_ctrl(input int b, input int c, input logic [7:0] data);
        write_reg({b[0], 4'hC, c[3:0]}, data);
        ctrl_m[b][c] = data;
    endtask

    task automatic write_mode(input logic is_new, input logic [5:0] conn);
        write_reg(9'h105, {7'd0, is_new});
        write_reg(9'h104, {2'd0, conn});
        new_m = is_new;
        conn_m = conn;
    endtask

    task automatic write_op(input int idx, input int val);
        op_we = 1'b1;
        op_addr = idx[5:0];
        op_data = val[`OPL3_OP_OUT_WIDTH-1:0];
        @(negedge clk);
        op_we = 1'b0;
        op_m[idx] = val;
    endtask

    task automatic load_random(input logic is_new, input logic [5:0] conn);
        write_mode(is_new, conn);
        for (int b = 0; b < 2; b++)
            for (int c = 0; c < 9; c++)
                write_ctrl(b, c, 8'($urandom));
        for (int i = 0; i < 36; i++)
            write_op(i, int'($urandom % 8192) - 4096); // full 13-bit range
    endtask

    // cycles counts rising edges after the accepting one until sample_valid
    task automatic run_pass(input bit extra_start, output int cycles);
        sample_clk_en = 1'b1;
        @(negedge clk);
        sample_clk_en = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            sample_clk_en = extra_start && cycles == 5; // ignored mid-pass
        end while (!sample_valid);
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int e0;
        int cycles;
        bit extra_pulse;
        clk = 1'b0;
        reset = 1'b1;
        sample_clk_en = 1'b0;
        reg_we = 1'b0;
        reg_addr = '0;
        reg_data = '0;
        op_we = 1'b0;
        op_addr = '0;
        op_data = '0;
        void'($urandom(32'ha95e_7a48));
        repeat (8) @(negedge clk);
        reset = 1'b0;

        e0 = errors;
        repeat (3) begin
            @(negedge clk);
            check_value("sample_valid", 0, sample_valid);
        end
        check_value("channel_a", 0, channel_a);
        check_value("channel_b", 0, channel_b);
        check_value("channel_c", 0, channel_c);
        check_value("channel_d", 0, channel_d);
        end_test("reset state", e0);

        e0 = errors;
        repeat (4) begin
            load_random(1'b1, 6'd0);
            run_pass(1'b0, cycles);
            compare_outputs();
        end
        end_test("two-op new mode", e0);

        e0 = errors;
        for (int p = 0; p < 4; p++) begin
            load_random(1'b1, (p == 0) ? 6'h3F : 6'($urandom));
            run_pass(1'b0, cycles);
            compare_outputs();
        end
        end_test("four-op pairing", e0);

        e0 = errors;
        repeat (3) begin
            load_random(1'b0, 6'($urandom)); // pairing has no effect here
            run_pass(1'b0, cycles);
            compare_outputs();
        end
        end_test("opl2 mode", e0);

        e0 = errors;
        for (int s = 0; s < 2; s++) begin
            write_mode(1'b1, 6'd0);
            for (int b = 0; b < 2; b++)
                for (int c = 0; c < 9; c++)
                    write_ctrl(b, c, 8'hF1); // all outputs, cnt set
            for (int i = 0; i < 36; i++)
                write_op(i, (s == 0) ? 4095 : -4096);
            run_pass(1'b0, cycles);
            compare_outputs();
            check_value("channel_a", (s == 0) ? 32767 : -32768, channel_a);
            check_value("channel_d", (s == 0) ? 32767 : -32768, channel_d);
        end
        end_test("saturation", e0);

        e0 = errors;
        load_random(1'b1, 6'($urandom));
        run_pass(1'b1, cycles);
        check_value("pass cycles", 19, cycles);
        compare_outputs();
        @(negedge clk);
        check_value("sample_valid", 0, sample_valid);
        extra_pulse = 1'b0;
        repeat (25) begin
            @(negedge clk);
            if (sample_valid)
                extra_pulse = 1'b1;
        end
        if (extra_pulse) begin
            errors++;
            $display("a second sample_clk_en during the pass caused another sample_valid");
        end
        compare_outputs(); // outputs held since the load
        end_test("pass timing", e0);

        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end
endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hdl
hdl/opl3_mix_pkg.sv
hdl/slot_if.sv
hdl/mix_sequencer.sv
hdl/slot_counter.sv
hdl/operator_sample_ram.sv
hdl/channel_config_regs.sv
hdl/channel_combiner.sv
hdl/output_accumulator.sv
hdl/opl3_channel_mixer.sv
sim/tb_opl3_channel_mixer.sv

// ==== Makefile ====
TOP := tb_opl3_channel_mixer
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
